// File: rtl/mac_params.svh
`ifndef MAC_PARAMS_SVH
`define MAC_PARAMS_SVH

////////////////////////////////////////////////////////////////////////////
// global sizes of the multiply-accumulate subsystem
////////////////////////////////////////////////////////////////////////////

// operand and result width, one word
`define MAC_XLEN 32

// sequence tag width, tags wrap at 16
`define MAC_TAG_W 4

// request entries between decoder and multiplier
`define MAC_FIFO_DEPTH 4

`endif

// File: rtl/mac_pkg.sv
`default_nettype none

`include "mac_params.svh"

package mac_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // multiplier operations
  ////////////////////////////////////////////////////////////////////////////

  // same encoding as the core's multiplier operator field
  typedef enum logic [2:0] {
    MUL_MAC32 = 3'b000,
    MUL_MSU32 = 3'b001,
    MUL_I     = 3'b010,
    MUL_IR    = 3'b011,
    MUL_DOT8  = 3'b100,
    MUL_DOT16 = 3'b101,
    MUL_H     = 3'b110
  } mult_op_e;

  ////////////////////////////////////////////////////////////////////////////
  // command, request and response
  ////////////////////////////////////////////////////////////////////////////

  // raw command as it arrives from outside
  typedef struct packed {
    logic [4:0]           opcode;
    logic [`MAC_XLEN-1:0] op_a;
    logic [`MAC_XLEN-1:0] op_b;
    logic [`MAC_XLEN-1:0] op_c;
    logic [4:0]           imm;
    logic                 upper_half;
  } mac_cmd_t;

  // decoded request, signed_ops bit 0 for op_a and bit 1 for op_b
  typedef struct packed {
    mult_op_e              operator;
    logic [1:0]            signed_ops;
    logic                  subword;
    logic [4:0]            imm;
    logic [`MAC_XLEN-1:0]  op_a;
    logic [`MAC_XLEN-1:0]  op_b;
    logic [`MAC_XLEN-1:0]  op_c;
    logic [`MAC_TAG_W-1:0] tag;
  } mul_req_t;

  // result strobe payload
  typedef struct packed {
    logic [`MAC_XLEN-1:0]  result;
    logic [`MAC_TAG_W-1:0] tag;
  } mul_rsp_t;

endpackage

`default_nettype wire

// File: rtl/mac_decoder.sv
`default_nettype none

`include "mac_params.svh"

module mac_decoder import mac_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     cmd_valid_i,
  input  mac_cmd_t cmd_i,
  output logic     req_valid_o,
  output mul_req_t req_o,
  output logic     err_o
);

  mult_op_e              dec_op;
  logic [1:0]            dec_signed;
  logic                  dec_legal;
  logic                  dec_accept;
  logic [`MAC_TAG_W-1:0] tag_q;

  ////////////////////////////////////////////////////////////////////////////
  // opcode table
  ////////////////////////////////////////////////////////////////////////////

  // opcode[4:2] picks the operation, opcode[1:0] carries the signedness
  always_comb begin
    dec_op     = MUL_MAC32;
    dec_signed = cmd_i.opcode[1:0];
    dec_legal  = 1'b1;
    case (cmd_i.opcode[4:2])
      3'b000: begin
        // 00 mac, 01 msu, signedness does not matter for the low word
        dec_signed = 2'b11;
        dec_op     = cmd_i.opcode[0] ? MUL_MSU32 : MUL_MAC32;
        if (cmd_i.opcode[1]) begin
          dec_legal = 1'b0;
        end
      end
      3'b001: dec_op = MUL_I;
      3'b010: dec_op = MUL_IR;
      3'b011: begin
        // mulhu 00, mulhsu 01, mulh 11, the b-only signed form is not defined
        dec_op = MUL_H;
        if (cmd_i.opcode[1:0] == 2'b10) begin
          dec_legal = 1'b0;
        end
      end
      3'b100: dec_op = MUL_DOT8;
      3'b101: dec_op = MUL_DOT16;
      default: dec_legal = 1'b0;
    endcase
  end

  assign dec_accept = cmd_valid_i & dec_legal;

  ////////////////////////////////////////////////////////////////////////////
  // request register and tag counter
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      req_valid_o <= 1'b0;
      err_o       <= 1'b0;
      tag_q       <= '0;
    end else begin
      req_valid_o <= dec_accept;
      // tag only advances for accepted commands
      if (dec_accept) begin
        tag_q <= tag_q + 1'b1;
      end
      // sticky until reset
      if (cmd_valid_i && !dec_legal) begin
        err_o <= 1'b1;
      end
    end
  end

  // payload only, qualified by req_valid_o
  always_ff @(posedge clk) begin
    if (dec_accept) begin
      req_o.operator   <= dec_op;
      req_o.signed_ops <= dec_signed;
      // upper halfwords only mean something for the short multiplies
      req_o.subword    <= cmd_i.upper_half & ((dec_op == MUL_I) || (dec_op == MUL_IR));
      req_o.imm        <= cmd_i.imm;
      req_o.op_a       <= cmd_i.op_a;
      req_o.op_b       <= cmd_i.op_b;
      req_o.op_c       <= cmd_i.op_c;
      req_o.tag        <= tag_q;
    end
  end

  // a pushed request carries no unknown operation, signedness or operand bits
  req_known: assert property (@(posedge clk) disable iff (!rst_n)
    req_valid_o |-> !$isunknown(req_o));

endmodule

`default_nettype wire

// File: rtl/req_fifo.sv
`default_nettype none

`include "mac_params.svh"

module req_fifo import mac_pkg::*; #(
  parameter int unsigned DEPTH  = `MAC_FIFO_DEPTH,
  parameter type         data_t = mul_req_t
) (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  push_i,
  input  data_t data_i,
  input  logic  pop_i,
  output data_t data_o,
  output logic  empty_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  data_t            mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             full;
  logic             do_push;
  logic             do_pop;

  // wraps explicitly so depths that are not a power of two work too
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    logic [PTR_W-1:0] nxt;
    nxt = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    return nxt;
  endfunction

  assign full    = (count_q == CNT_W'(DEPTH));
  assign empty_o = (count_q == '0);

  // a pop frees the slot in the same cycle, so push on full is fine then
  assign do_push = push_i & (~full | pop_i);
  assign do_pop  = pop_i & ~empty_o;

  // head entry straight from storage
  assign data_o = mem_q[rd_ptr_q];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= ptr_next(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= ptr_next(rd_ptr_q);
      end
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // strobe sources have no back-pressure, overfilling is a source error
  no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    (push_i && full) |-> pop_i);

  no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
    pop_i |-> !empty_o);

endmodule

`default_nettype wire

// File: rtl/subword_mult.sv
`default_nettype none

module subword_mult import mac_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  mul_req_t req_i,
  input  logic     req_empty_i,
  output logic     pop_o,
  output logic     rsp_valid_o,
  output mul_rsp_t rsp_o
);

  typedef enum logic [2:0] {IDLE, STEP0, STEP1, STEP2, FINISH} mulh_state_e;

  mul_req_t    req_q;
  logic        exec_q;
  logic        rsp_valid_d;
  logic [31:0] result;

  ////////////////////////////////////////////////////////////////////////////
  // issue
  ////////////////////////////////////////////////////////////////////////////

  mulh_state_e mulh_cs;
  mulh_state_e mulh_ns;

  // idle, or mulh in its last step, so the next request can come in
  assign pop_o = ((mulh_cs == IDLE) || (mulh_cs == FINISH)) & ~req_empty_i;

  always_ff @(posedge clk) begin
    if (pop_o) begin
      req_q <= req_i;
    end
  end

  // single-cycle operations execute in the cycle after the pop
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      exec_q <= 1'b0;
    end else begin
      exec_q <= pop_o & (req_i.operator != MUL_H);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // short multiplier, shared by mul_i, mul_ir and the mulh steps
  ////////////////////////////////////////////////////////////////////////////

  logic               mulh_active;
  logic               mulh_save;
  logic [4:0]         mulh_imm;
  logic [1:0]         mulh_subword;
  logic [1:0]         mulh_signed;
  logic               mulh_carry_q;
  logic [31:0]        mulh_acc_q;

  logic [4:0]         short_imm;
  logic [1:0]         short_subword;
  logic [1:0]         short_signed;
  logic [15:0]        short_half_a;
  logic [15:0]        short_half_b;
  logic [16:0]        short_op_a;
  logic [16:0]        short_op_b;
  logic [32:0]        short_op_c;
  logic [31:0]        short_round_tmp;
  logic [31:0]        short_round;
  logic [33:0]        short_mac;
  logic               short_fill;
  logic signed [33:0] short_ext;
  logic [33:0]        short_result;

  // mulh steps override the request fields
  assign mulh_active   = (mulh_cs != IDLE);
  assign short_imm     = mulh_active ? mulh_imm     : req_q.imm;
  assign short_subword = mulh_active ? mulh_subword : {2{req_q.subword}};
  assign short_signed  = mulh_active ? mulh_signed  : req_q.signed_ops;

  // half of one at the shift position, mul_ir only
  assign short_round_tmp = 32'h0000_0001 << req_q.imm;
  assign short_round     = (req_q.operator == MUL_IR) ? {1'b0, short_round_tmp[31:1]} : '0;

  // halfword select, bit 0 for a and bit 1 for b
  assign short_half_a = short_subword[0] ? req_q.op_a[31:16] : req_q.op_a[15:0];
  assign short_half_b = short_subword[1] ? req_q.op_b[31:16] : req_q.op_b[15:0];
  assign short_op_a   = {short_signed[0] & short_half_a[15], short_half_a};
  assign short_op_b   = {short_signed[1] & short_half_b[15], short_half_b};

  // during mulh the addend is the 33-bit partial sum from the last step
  assign short_op_c = mulh_active ? {mulh_carry_q, mulh_acc_q} : {1'b0, req_q.op_c};

  assign short_mac = $signed(short_op_c) + $signed(short_op_a) * $signed(short_op_b)
                   + $signed({1'b0, short_round});

  // mul_i and mul_ir shift the 32-bit sum, sign fill only when a is signed
  assign short_fill   = req_q.signed_ops[0] & short_mac[31];
  // mulh keeps the exact 34-bit sum so the shift is a true floor division
  assign short_ext    = mulh_active ? short_mac : {short_fill, short_fill, short_mac[31:0]};
  assign short_result = short_ext >>> short_imm;

  ////////////////////////////////////////////////////////////////////////////
  // mulh sequencer
  ////////////////////////////////////////////////////////////////////////////

  // al*bl, then ah*bl, then al*bh, then ah*bh, with 16-bit shifts in between
  always_comb begin
    mulh_ns      = mulh_cs;
    mulh_imm     = 5'd0;
    mulh_subword = 2'b00;
    mulh_signed  = 2'b00;
    mulh_save    = 1'b0;
    case (mulh_cs)
      IDLE: begin
        if (pop_o && (req_i.operator == MUL_H)) begin
          mulh_ns = STEP0;
        end
      end
      STEP0: begin
        // both low halves unsigned
        mulh_imm  = 5'd16;
        mulh_save = 1'b1;
        mulh_ns   = STEP1;
      end
      STEP1: begin
        mulh_signed  = {1'b0, req_q.signed_ops[0]};
        mulh_subword = 2'b01;
        mulh_save    = 1'b1;
        mulh_ns      = STEP2;
      end
      STEP2: begin
        mulh_signed  = {req_q.signed_ops[1], 1'b0};
        mulh_subword = 2'b10;
        mulh_imm     = 5'd16;
        mulh_save    = 1'b1;
        mulh_ns      = FINISH;
      end
      FINISH: begin
        mulh_signed  = req_q.signed_ops;
        mulh_subword = 2'b11;
        // back to back mulh skips idle
        mulh_ns      = (pop_o && (req_i.operator == MUL_H)) ? STEP0 : IDLE;
      end
      default: mulh_ns = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mulh_cs      <= IDLE;
      mulh_carry_q <= 1'b0;
      mulh_acc_q   <= '0;
    end else begin
      mulh_cs <= mulh_ns;
      // partial sum fits 33 bits signed, bit 32 is the saved carry
      if (mulh_save) begin
        {mulh_carry_q, mulh_acc_q} <= short_result[32:0];
      end else begin
        {mulh_carry_q, mulh_acc_q} <= '0;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // integer mac and msu, low word only
  ////////////////////////////////////////////////////////////////////////////

  logic [31:0] int_prod;
  logic [31:0] int_result;

  assign int_prod   = req_q.op_a * req_q.op_b;
  assign int_result = (req_q.operator == MUL_MSU32) ? req_q.op_c - int_prod
                                                    : req_q.op_c + int_prod;

  ////////////////////////////////////////////////////////////////////////////
  // dot products
  ////////////////////////////////////////////////////////////////////////////

  logic [3:0][8:0]  dot_char_a;
  logic [3:0][8:0]  dot_char_b;
  logic [3:0][17:0] dot_char_mul;
  logic [1:0][16:0] dot_short_a;
  logic [1:0][16:0] dot_short_b;
  logic [1:0][33:0] dot_short_mul;
  logic [31:0]      dot_char_result;
  logic [31:0]      dot_short_result;

  // lane sign extension per operand
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      dot_char_a[i]   = {req_q.signed_ops[0] & req_q.op_a[8*i+7], req_q.op_a[8*i +: 8]};
      dot_char_b[i]   = {req_q.signed_ops[1] & req_q.op_b[8*i+7], req_q.op_b[8*i +: 8]};
      dot_char_mul[i] = $signed(dot_char_a[i]) * $signed(dot_char_b[i]);
    end
    for (int j = 0; j < 2; j++) begin
      dot_short_a[j]   = {req_q.signed_ops[0] & req_q.op_a[16*j+15], req_q.op_a[16*j +: 16]};
      dot_short_b[j]   = {req_q.signed_ops[1] & req_q.op_b[16*j+15], req_q.op_b[16*j +: 16]};
      dot_short_mul[j] = $signed(dot_short_a[j]) * $signed(dot_short_b[j]);
    end
  end

  assign dot_char_result = $signed(dot_char_mul[0]) + $signed(dot_char_mul[1])
                         + $signed(dot_char_mul[2]) + $signed(dot_char_mul[3])
                         + $signed(req_q.op_c);

  // halfword products truncated to the word before the sum
  assign dot_short_result = dot_short_mul[0][31:0] + dot_short_mul[1][31:0] + req_q.op_c;

  ////////////////////////////////////////////////////////////////////////////
  // result select and response register
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    result = '0;
    case (req_q.operator)
      MUL_MAC32, MUL_MSU32: result = int_result;
      MUL_I, MUL_IR, MUL_H: result = short_result[31:0];
      MUL_DOT8:             result = dot_char_result;
      MUL_DOT16:            result = dot_short_result;
      default:              result = '0;
    endcase
  end

  assign rsp_valid_d = exec_q | (mulh_cs == FINISH);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rsp_valid_o <= 1'b0;
    end else begin
      rsp_valid_o <= rsp_valid_d;
    end
  end

  always_ff @(posedge clk) begin
    if (rsp_valid_d) begin
      rsp_o.result <= result;
      rsp_o.tag    <= req_q.tag;
    end
  end

  // four steps of the sequencer against the full 64-bit product
  mulh_ss_check: assert property (@(posedge clk) disable iff (!rst_n)
    ((mulh_cs == FINISH) && (req_q.signed_ops == 2'b11))
    |-> (result == 32'(($signed({{32{req_q.op_a[31]}}, req_q.op_a})
                        * $signed({{32{req_q.op_b[31]}}, req_q.op_b})) >> 32)));

  mulh_su_check: assert property (@(posedge clk) disable iff (!rst_n)
    ((mulh_cs == FINISH) && (req_q.signed_ops == 2'b01))
    |-> (result == 32'(($signed({{32{req_q.op_a[31]}}, req_q.op_a})
                        * $signed({32'b0, req_q.op_b})) >> 32)));

  mulh_uu_check: assert property (@(posedge clk) disable iff (!rst_n)
    ((mulh_cs == FINISH) && (req_q.signed_ops == 2'b00))
    |-> (result == 32'(({32'b0, req_q.op_a} * {32'b0, req_q.op_b}) >> 32)));

endmodule

`default_nettype wire

// File: rtl/mac_top.sv
`default_nettype none

`include "mac_params.svh"

module mac_top import mac_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     cmd_valid_i,
  input  mac_cmd_t cmd_i,
  output logic     rsp_valid_o,
  output mul_rsp_t rsp_o,
  output logic     err_o
);

  // decoder to fifo
  logic     req_push;
  mul_req_t req_d;

  // fifo to multiplier
  logic     fifo_empty;
  mul_req_t req_head;
  logic     req_pop;

  mac_decoder u_decoder (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmd_valid_i (cmd_valid_i),
    .cmd_i       (cmd_i),
    .req_valid_o (req_push),
    .req_o       (req_d),
    .err_o       (err_o)
  );

  req_fifo #(
    .DEPTH  (`MAC_FIFO_DEPTH),
    .data_t (mul_req_t)
  ) u_req_fifo (
    .clk     (clk),
    .rst_n   (rst_n),
    .push_i  (req_push),
    .data_i  (req_d),
    .pop_i   (req_pop),
    .data_o  (req_head),
    .empty_o (fifo_empty)
  );

  subword_mult u_mult (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_i       (req_head),
    .req_empty_i (fifo_empty),
    .pop_o       (req_pop),
    .rsp_valid_o (rsp_valid_o),
    .rsp_o       (rsp_o)
  );

endmodule

`default_nettype wire

// File: tb/mac_ref_model.svh
`ifndef MAC_REF_MODEL_SVH
`define MAC_REF_MODEL_SVH

  ////////////////////////////////////////////////////////////////////////////
  // opcode table, class in opcode[4:2] and signedness in opcode[1:0]
  ////////////////////////////////////////////////////////////////////////////

  localparam logic [2:0] OPC_INT   = 3'b000;
  localparam logic [2:0] OPC_MULI  = 3'b001;
  localparam logic [2:0] OPC_MULIR = 3'b010;
  localparam logic [2:0] OPC_MULH  = 3'b011;
  localparam logic [2:0] OPC_DOT8  = 3'b100;
  localparam logic [2:0] OPC_DOT16 = 3'b101;

  // returns 1 for a legal opcode
  function automatic bit decode_opcode(input logic [4:0] opcode, output mult_op_e op,
                                       output logic [1:0] sgn);
    bit legal;
    legal = 1'b1;
    op    = MUL_MAC32;
    sgn   = opcode[1:0];
    case (opcode[4:2])
      OPC_INT: begin
        op    = opcode[0] ? MUL_MSU32 : MUL_MAC32;
        legal = !opcode[1];
      end
      OPC_MULI:  op = MUL_I;
      OPC_MULIR: op = MUL_IR;
      OPC_MULH: begin
        // only b signed has no mulh form
        op    = MUL_H;
        legal = (opcode[1:0] != 2'b10);
      end
      OPC_DOT8:  op = MUL_DOT8;
      OPC_DOT16: op = MUL_DOT16;
      default:   legal = 1'b0;
    endcase
    return legal;
  endfunction

  // class 0 mac, 1 msu, 2 mul_i, 3 mul_ir, 4 mulh, 5 dot8, 6 dot16
  function automatic logic [4:0] legal_opcode(input int cls, input logic [1:0] sgn);
    logic [4:0] opc;
    case (cls)
      0:       opc = {OPC_INT, 2'b00};
      1:       opc = {OPC_INT, 2'b01};
      2:       opc = {OPC_MULI, sgn};
      3:       opc = {OPC_MULIR, sgn};
      4:       opc = {OPC_MULH, (sgn == 2'b10) ? 2'b11 : sgn};
      5:       opc = {OPC_DOT8, sgn};
      default: opc = {OPC_DOT16, sgn};
    endcase
    return opc;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // expected results
  ////////////////////////////////////////////////////////////////////////////

  // 16x16 plus addend, optional rounding, then shift of the low word
  function automatic logic [31:0] shifted_short_mac(input mac_cmd_t cmd, input logic [1:0] sgn,
                                                    input bit round);
    logic [15:0] xa;
    logic [15:0] xb;
    longint      ha;
    longint      hb;
    longint      cz;
    longint      rnd;
    longint      sum;
    logic [31:0] low;
    xa = cmd.upper_half ? cmd.op_a[31:16] : cmd.op_a[15:0];
    xb = cmd.upper_half ? cmd.op_b[31:16] : cmd.op_b[15:0];
    if (sgn[0]) ha = $signed(xa);
    else        ha = xa;
    if (sgn[1]) hb = $signed(xb);
    else        hb = xb;
    cz  = cmd.op_c;
    rnd = (round && (cmd.imm != 0)) ? (longint'(1) << (cmd.imm - 1)) : 0;
    sum = cz + ha * hb + rnd;
    low = sum[31:0];
    if (sgn[0]) return $signed(low) >>> cmd.imm;
    return low >> cmd.imm;
  endfunction

  // upper word of the full product, a signed by bit 0 and b by bit 1
  function automatic logic [31:0] upper_product(input logic [31:0] a, input logic [31:0] b,
                                                input logic [1:0] sgn);
    logic [63:0] ua;
    logic [63:0] ub;
    logic [63:0] p;
    longint      sa;
    longint      sb;
    if (sgn == 2'b00) begin
      ua = a;
      ub = b;
      p  = ua * ub;
    end else begin
      sa = $signed(a);
      if (sgn[1]) sb = $signed(b);
      else        sb = b;
      p = sa * sb;
    end
    return p[63:32];
  endfunction

  function automatic logic [31:0] dot_product(input mac_cmd_t cmd, input logic [1:0] sgn,
                                              input bit wide);
    longint acc;
    longint la;
    longint lb;
    acc = cmd.op_c;
    for (int i = 0; i < (wide ? 2 : 4); i++) begin
      if (wide) begin
        if (sgn[0]) la = $signed(cmd.op_a[16*i +: 16]);
        else        la = cmd.op_a[16*i +: 16];
        if (sgn[1]) lb = $signed(cmd.op_b[16*i +: 16]);
        else        lb = cmd.op_b[16*i +: 16];
      end else begin
        if (sgn[0]) la = $signed(cmd.op_a[8*i +: 8]);
        else        la = cmd.op_a[8*i +: 8];
        if (sgn[1]) lb = $signed(cmd.op_b[8*i +: 8]);
        else        lb = cmd.op_b[8*i +: 8];
      end
      acc = acc + la * lb;
    end
    return acc[31:0];
  endfunction

  function automatic logic [31:0] expected_result(input mult_op_e op, input logic [1:0] sgn,
                                                  input mac_cmd_t cmd);
    case (op)
      MUL_MAC32: return cmd.op_c + cmd.op_a * cmd.op_b;
      MUL_MSU32: return cmd.op_c - cmd.op_a * cmd.op_b;
      MUL_I:     return shifted_short_mac(cmd, sgn, 1'b0);
      MUL_IR:    return shifted_short_mac(cmd, sgn, 1'b1);
      MUL_H:     return upper_product(cmd.op_a, cmd.op_b, sgn);
      MUL_DOT8:  return dot_product(cmd, sgn, 1'b0);
      default:   return dot_product(cmd, sgn, 1'b1);
    endcase
  endfunction

`endif

// File: tb/tb_mac_top.sv
`default_nettype none

`include "mac_params.svh"

module tb_mac_top import mac_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  `include "mac_ref_model.svh"

  // commands per test
  localparam int N_INT       = 16;
  localparam int N_SHORT     = 32;
  localparam int N_MULH      = 24;
  localparam int N_DOT       = 24;
  localparam int N_MIX       = 40;
  localparam int N_ILL       = 9;
  localparam int TOTAL_CMDS  = N_INT + N_SHORT + N_MULH + N_DOT + N_MIX + N_ILL;
  localparam int CYCLE_LIMIT = 8 * TOTAL_CMDS + 100;

  logic     clk = 1'b0;
  logic     rst_n;
  logic     cmd_valid_i;
  mac_cmd_t cmd_i;
  logic     rsp_valid_o;
  mul_rsp_t rsp_o;
  logic     err_o;

  // scoreboard state
  mul_rsp_t              exp_q[$];
  logic [`MAC_TAG_W-1:0] tag_model = '0;
  integer                seed = 29989;
  int                    errors = 0;
  int                    checks = 0;
  int                    tests_pass = 0;
  int                    tests_fail = 0;
  int                    burst_cnt = 0;
  int                    cycles = 0;

  mac_top DUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmd_valid_i (cmd_valid_i),
    .cmd_i       (cmd_i),
    .rsp_valid_o (rsp_valid_o),
    .rsp_o       (rsp_o),
    .err_o       (err_o)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout after %0d cycles, %0d results still outstanding", cycles, exp_q.size());
      $display("Test failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_rsp(input mul_rsp_t got, input mul_rsp_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at %0t: got tag %0d result %h, expected tag %0d result %h",
               $time, got.tag, got.result, exp.tag, exp.result);
    end
  endtask

  task automatic check_err(input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at %0t: err_o is %b, expected %b", $time, got, exp);
    end
  endtask

  // sampled mid-cycle, away from the edge
  always @(negedge clk) begin
    if (rst_n && rsp_valid_o) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("a response with tag %0d arrived at %0t with no command outstanding",
                 rsp_o.tag, $time);
      end else begin
        check_rsp(rsp_o, exp_q.pop_front());
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic int rand_below(input int n);
    return {$random(seed)} % n;
  endfunction

  function automatic mac_cmd_t random_cmd();
    mac_cmd_t cmd;
    cmd.opcode     = '0;
    cmd.op_a       = $random(seed);
    cmd.op_b       = $random(seed);
    cmd.op_c       = $random(seed);
    cmd.imm        = $random(seed);
    cmd.upper_half = $random(seed);
    return cmd;
  endfunction

  // operands that stress the mulh carry path
  function automatic logic [31:0] corner_word(input int idx);
    case (idx % 4)
      0:       return 32'h8000_0000;
      1:       return 32'hffff_ffff;
      2:       return 32'h7fff_ffff;
      default: return 32'h0000_ffff;
    endcase
  endfunction

  function automatic logic [4:0] illegal_opcode();
    case (rand_below(4))
      0:       return {3'b110, 2'(rand_below(4))};
      1:       return {3'b111, 2'(rand_below(4))};
      2:       return {3'b000, 1'b1, 1'(rand_below(2))};
      default: return 5'b011_10;
    endcase
  endfunction

  task automatic wait_drain();
    while (exp_q.size() != 0) begin
      @(posedge clk);
      #1;
    end
    burst_cnt = 0;
  endtask

  // one strobe, expected result queued for legal opcodes
  task automatic send_cmd(input mac_cmd_t cmd);
    mult_op_e   op;
    logic [1:0] sgn;
    mul_rsp_t   exp;
    if (decode_opcode(cmd.opcode, op, sgn)) begin
      exp.result = expected_result(op, sgn, cmd);
      exp.tag    = tag_model;
      tag_model  = tag_model + 1'b1;
      exp_q.push_back(exp);
    end
    cmd_i       = cmd;
    cmd_valid_i = 1'b1;
    @(posedge clk);
    #1;
    cmd_valid_i = 1'b0;
    burst_cnt++;
    // never more in flight than the FIFO holds
    if (burst_cnt == `MAC_FIFO_DEPTH) begin
      wait_drain();
    end
  endtask

  task automatic report_test(input string name, input int err_start);
    if (errors == err_start) begin
      tests_pass++;
      $display("%-14s passed", name);
    end else begin
      tests_fail++;
      $display("%-14s FAILED with %0d errors", name, errors - err_start);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    mac_cmd_t   cmd;
    logic [1:0] sgn;
    int         err_start;
    cmd_valid_i = 1'b0;
    cmd_i       = '0;
    rst_n       = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;

    err_start = errors;
    for (int i = 0; i < N_INT; i++) begin
      cmd        = random_cmd();
      cmd.opcode = legal_opcode(rand_below(2), 2'b00);
      send_cmd(cmd);
    end
    wait_drain();
    report_test("mac32/msu32", err_start);

    err_start = errors;
    for (int i = 0; i < N_SHORT; i++) begin
      cmd        = random_cmd();
      cmd.opcode = legal_opcode(2 + rand_below(2), 2'(rand_below(4)));
      send_cmd(cmd);
    end
    wait_drain();
    report_test("mul_i/mul_ir", err_start);

    // all three forms in turn
    err_start = errors;
    for (int i = 0; i < N_MULH; i++) begin
      cmd = random_cmd();
      sgn = (i % 3 == 0) ? 2'b00 : ((i % 3 == 1) ? 2'b01 : 2'b11);
      cmd.opcode = legal_opcode(4, sgn);
      if (i % 4 == 3) begin
        cmd.op_a = corner_word(i / 4);
        cmd.op_b = corner_word(i / 4 + i / 12);
      end
      send_cmd(cmd);
    end
    wait_drain();
    report_test("mulh", err_start);

    err_start = errors;
    for (int i = 0; i < N_DOT; i++) begin
      cmd        = random_cmd();
      cmd.opcode = legal_opcode(5 + rand_below(2), 2'(rand_below(4)));
      send_cmd(cmd);
    end
    wait_drain();
    report_test("dot8/dot16", err_start);

    err_start = errors;
    for (int i = 0; i < N_MIX; i++) begin
      cmd        = random_cmd();
      cmd.opcode = legal_opcode(rand_below(7), 2'(rand_below(4)));
      send_cmd(cmd);
    end
    wait_drain();
    report_test("mixed burst", err_start);

    // illegal opcode in the middle, its slot takes no tag
    err_start = errors;
    check_err(err_o, 1'b0);
    for (int i = 0; i < N_ILL; i++) begin
      cmd        = random_cmd();
      cmd.opcode = (i == N_ILL / 2) ? illegal_opcode()
                                    : legal_opcode(rand_below(7), 2'(rand_below(4)));
      send_cmd(cmd);
    end
    wait_drain();
    check_err(err_o, 1'b1);
    report_test("illegal opcode", err_start);

    $display("summary: %0d tests passed, %0d tests failed, %0d checks, %0d errors",
             tests_pass, tests_fail, checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
+incdir+rtl
+incdir+tb
rtl/mac_pkg.sv
rtl/mac_decoder.sv
rtl/req_fifo.sv
rtl/subword_mult.sv
rtl/mac_top.sv
tb/tb_mac_top.sv

// File: Bender.yml
package:
  name: mac_subsystem

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/mac_pkg.sv
      - rtl/mac_decoder.sv
      - rtl/req_fifo.sv
      - rtl/subword_mult.sv
      - rtl/mac_top.sv
  - target: test
    include_dirs:
      - rtl
      - tb
    files:
      - tb/tb_mac_top.sv
